// ==== rtl/sd_pkg.sv ====
`default_nettype none

package sd_pkg;

    // ======================================================================
    // Frame layout
    // ======================================================================

    localparam int SD_FRAME_BITS = 48;

    // Frame bits 47 down to 8 go through the CRC7
    localparam int SD_CRC_COVER_BITS = 40;

    // Start bit 47, index 45:40, CRC 7:1, end bit 0
    typedef logic [SD_FRAME_BITS-1:0] sd_frame_t;

    typedef logic [6:0] sd_crc7_t;

    typedef enum logic [1:0] {
        RESP_NONE = 2'b00,
        RESP_48   = 2'b01
    } sd_resp_type_e;

    // ======================================================================
    // Timing
    // ======================================================================

    // Cycles after CMD is released before the card side is sampled
    localparam int SD_TURNAROUND_CYCLES = 2;

    // Low-voltage power-up sequence, in microseconds
    localparam int INIT_PULSE_US          = 15;
    localparam int INIT_HOLD_US           = 5;
    localparam int INIT_FINISH_US_DEFAULT = 5500;

endpackage

`default_nettype wire

// ==== rtl/sd_crc7.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_crc7 (
    input  wire              clk_fast,
    input  wire              init_resetPulse,
    input  wire              clear,
    input  wire              en,
    input  wire              din,
    output sd_pkg::sd_crc7_t crc
);

    // x^7 + x^3 + 1, the x^7 term is the bit shifted out of crc[6]
    localparam logic [6:0] POLY = 7'h09;

    logic feedback;

    assign feedback = din ^ crc[6];

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (en) begin
            crc <= {crc[5:0], 1'b0} ^ (feedback ? POLY : 7'h00);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sd_cmd_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_cmd_tx (
    input  wire               clk_fast,
    input  wire               init_resetPulse,
    input  wire               cmd_trigger,
    input  wire sd_pkg::sd_frame_t cmd_data,
    output logic              cmd_out,
    output logic              cmd_oe,
    output logic              cmd_done,
    output logic              cmd_sent
);
    import sd_pkg::*;

    localparam int CNT_W = $clog2(SD_FRAME_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT  = CNT_W'(SD_FRAME_BITS - 1);
    localparam logic [CNT_W-1:0] DONE_BIT  = CNT_W'(SD_FRAME_BITS - 2);
    localparam logic [CNT_W-1:0] CRC_FIRST = CNT_W'(SD_CRC_COVER_BITS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_SHIFT
    } tx_state_e;

    tx_state_e        state;
    logic             trigger_q;
    logic             trigger_pulse;
    sd_frame_t        shift_reg;
    logic [CNT_W-1:0] bit_cnt;
    logic             crc_phase;
    logic             crc_clear;
    logic             crc_en;
    logic             crc_din;
    sd_crc7_t         crc;

    assign trigger_pulse = cmd_trigger ^ trigger_q;

    // ======================================================================
    // Sequencing
    // ======================================================================

    always_ff @(posedge clk_fast) begin
        trigger_q <= cmd_trigger;
        if (init_resetPulse) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            cmd_done <= 1'b0;
        end else if (trigger_pulse) begin
            // Restart, even in the middle of a frame
            state <= ST_CLEAR;
        end else begin
            case (state)
                ST_CLEAR: begin
                    bit_cnt <= '0;
                    state   <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    // Toggle lands in the last bit cycle
                    if (bit_cnt == DONE_BIT) begin
                        cmd_done <= ~cmd_done;
                    end
                    if (bit_cnt == LAST_BIT) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_fast) begin
        if (state == ST_CLEAR) begin
            shift_reg <= cmd_data;
        end else if (state == ST_SHIFT) begin
            shift_reg <= shift_reg << 1;
        end
    end

    // ======================================================================
    // CRC insertion
    // ======================================================================

    assign cmd_oe    = (state == ST_SHIFT);
    assign crc_phase = (bit_cnt >= CRC_FIRST) && (bit_cnt < LAST_BIT);
    assign crc_clear = (state == ST_CLEAR);
    assign crc_en    = cmd_oe && (bit_cnt < LAST_BIT);

    // Feeding back crc[6] turns the CRC into a plain shifter for bits 7:1
    assign crc_din  = crc_phase ? crc[6] : shift_reg[SD_FRAME_BITS-1];
    assign cmd_out  = cmd_oe ? crc_din : 1'b1;
    assign cmd_sent = cmd_oe && (bit_cnt == LAST_BIT);

    sd_crc7 i_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (crc_clear),
        .en              (crc_en),
        .din             (crc_din),
        .crc             (crc)
    );

endmodule

`default_nettype wire

// ==== rtl/sd_resp_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_resp_rx (
    input  wire                        clk_fast,
    input  wire                        init_resetPulse,
    input  wire                        cmd_sent,
    input  wire                        cmd_oe,
    input  wire sd_pkg::sd_resp_type_e cmd_resp_type,
    input  wire                        cmd_in,
    output sd_pkg::sd_frame_t          resp_data,
    output logic                       resp_done,
    output logic                       resp_crc_err
);
    import sd_pkg::*;

    localparam int CNT_W = $clog2(SD_FRAME_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT  = CNT_W'(SD_FRAME_BITS - 1);
    localparam logic [CNT_W-1:0] COVER_END = CNT_W'(SD_CRC_COVER_BITS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEARCH,
        ST_CAPTURE,
        ST_CHECK
    } rx_state_e;

    rx_state_e                       state;
    logic [SD_TURNAROUND_CYCLES-1:0] oe_hist;
    logic                            line;
    logic                            start_seen;
    sd_frame_t                       shift_reg;
    logic [CNT_W-1:0]                bit_cnt;
    logic                            crc_clear;
    logic                            crc_en;
    sd_crc7_t                        crc;

    // ======================================================================
    // Line turnaround
    // ======================================================================

    // CMD reads as idle while we drive it and for a short time afterwards
    assign line = (cmd_oe || (|oe_hist)) ? 1'b1 : cmd_in;

    assign start_seen = (state == ST_SEARCH) && !line;

    // Held clear while searching, so the start bit enters a fresh CRC
    assign crc_clear = (state == ST_SEARCH) && line;
    assign crc_en    = start_seen || ((state == ST_CAPTURE) && (bit_cnt < COVER_END));

    // ======================================================================
    // Receive FSM
    // ======================================================================

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state        <= ST_IDLE;
            oe_hist      <= '0;
            bit_cnt      <= '0;
            resp_done    <= 1'b0;
            resp_crc_err <= 1'b0;
            resp_data    <= '0;
        end else begin
            oe_hist <= (oe_hist << 1) | SD_TURNAROUND_CYCLES'(cmd_oe);
            if (cmd_sent) begin
                // Arms or aborts, depending on what the command expects
                if (cmd_resp_type == RESP_48) begin
                    state <= ST_SEARCH;
                end else begin
                    state <= ST_IDLE;
                end
            end else begin
                case (state)
                    ST_SEARCH: begin
                        if (!line) begin
                            bit_cnt <= CNT_W'(1);
                            state   <= ST_CAPTURE;
                        end
                    end
                    ST_CAPTURE: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state <= ST_CHECK;
                        end
                    end
                    ST_CHECK: begin
                        resp_data    <= shift_reg;
                        // Bad CRC field or a missing end bit
                        resp_crc_err <= (shift_reg[7:1] != crc) || !shift_reg[0];
                        resp_done    <= ~resp_done;
                        state        <= ST_IDLE;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_fast) begin
        if (start_seen || (state == ST_CAPTURE)) begin
            shift_reg <= {shift_reg[SD_FRAME_BITS-2:0], line};
        end
    end

    sd_crc7 i_crc7 (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (crc_clear),
        .en              (crc_en),
        .din             (line),
        .crc             (crc)
    );

endmodule

`default_nettype wire

// ==== rtl/sd_init_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_init_seq #(
    parameter int INIT_PULSE_CYCLES  = 15,
    parameter int INIT_HOLD_CYCLES   = 5,
    parameter int INIT_FINISH_CYCLES = 10
) (
    input  wire  clk_fast,
    input  wire  init_resetPulse,
    input  wire  init_trigger,
    output logic sd_clk_en,
    output logic drive_lines,
    output logic init_done
);

    localparam int MAX_PH = (INIT_PULSE_CYCLES > INIT_HOLD_CYCLES) ?
                            INIT_PULSE_CYCLES : INIT_HOLD_CYCLES;
    localparam int MAX_CYCLES = (INIT_FINISH_CYCLES > MAX_PH) ? INIT_FINISH_CYCLES : MAX_PH;
    localparam int CNT_W = $clog2(MAX_CYCLES + 1);

    // Counter runs down to zero, so each phase loads its length minus one
    localparam logic [CNT_W-1:0] PULSE_LOAD  = CNT_W'(INIT_PULSE_CYCLES - 1);
    localparam logic [CNT_W-1:0] HOLD_LOAD   = CNT_W'(INIT_HOLD_CYCLES - 1);
    localparam logic [CNT_W-1:0] FINISH_LOAD = CNT_W'(INIT_FINISH_CYCLES - 1);

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_PULSE,
        ST_HOLD,
        ST_RELEASE
    } init_state_e;

    init_state_e      state;
    logic [CNT_W-1:0] delay_cnt;
    logic             trigger_q;
    logic             trigger_pulse;

    assign trigger_pulse = init_trigger ^ trigger_q;

    always_ff @(posedge clk_fast) begin
        trigger_q <= init_trigger;
        if (init_resetPulse) begin
            state     <= ST_WAIT;
            delay_cnt <= '0;
            init_done <= 1'b0;
        end else if (trigger_pulse) begin
            state     <= ST_PULSE;
            delay_cnt <= PULSE_LOAD;
            init_done <= 1'b0;
        end else begin
            case (state)
                ST_PULSE: begin
                    if (delay_cnt == '0) begin
                        state     <= ST_HOLD;
                        delay_cnt <= HOLD_LOAD;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                ST_HOLD: begin
                    if (delay_cnt == '0) begin
                        state     <= ST_RELEASE;
                        delay_cnt <= FINISH_LOAD;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                // Lines released, card settling
                ST_RELEASE: begin
                    if (delay_cnt == '0) begin
                        state     <= ST_WAIT;
                        init_done <= 1'b1;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Single long clock pulse, then free running clock once ready
    assign sd_clk_en   = (state == ST_PULSE) || init_done;
    assign drive_lines = (state == ST_PULSE) || (state == ST_HOLD);

endmodule

`default_nettype wire

// ==== rtl/sd_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_controller #(
    parameter int CLK_FREQ_HZ    = 120_000_000,
    parameter int INIT_FINISH_US = sd_pkg::INIT_FINISH_US_DEFAULT
) (
    input  wire                        clk_fast,
    input  wire                        init_resetPulse,
    input  wire                        init_trigger,
    input  wire                        cmd_trigger,
    input  wire sd_pkg::sd_frame_t     cmd_data,
    input  wire sd_pkg::sd_resp_type_e cmd_resp_type,
    input  wire                        cmd_in,
    output logic                       sd_clk_en,
    output logic                       cmd_out,
    output logic                       cmd_oe,
    output logic                       dat_oe,
    output logic                       init_done,
    output logic                       cmd_done,
    output logic                       resp_done,
    output sd_pkg::sd_frame_t          resp_data,
    output logic                       resp_crc_err
);
    import sd_pkg::*;

    // Microseconds to clk_fast cycles, rounded up
    function automatic int us_to_cycles(input longint us);
        longint cycles;
        cycles = (us * CLK_FREQ_HZ + 999_999) / 1_000_000;
        return int'(cycles);
    endfunction

    localparam int INIT_PULSE_CYCLES  = us_to_cycles(INIT_PULSE_US);
    localparam int INIT_HOLD_CYCLES   = us_to_cycles(INIT_HOLD_US);
    localparam int INIT_FINISH_CYCLES = us_to_cycles(INIT_FINISH_US);

    logic drive_lines;
    logic tx_cmd_out;
    logic tx_cmd_oe;
    logic cmd_sent;

    sd_init_seq #(
        .INIT_PULSE_CYCLES  (INIT_PULSE_CYCLES),
        .INIT_HOLD_CYCLES   (INIT_HOLD_CYCLES),
        .INIT_FINISH_CYCLES (INIT_FINISH_CYCLES)
    ) i_init_seq (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .init_trigger    (init_trigger),
        .sd_clk_en       (sd_clk_en),
        .drive_lines     (drive_lines),
        .init_done       (init_done)
    );

    sd_cmd_tx i_cmd_tx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_trigger     (cmd_trigger),
        .cmd_data        (cmd_data),
        .cmd_out         (tx_cmd_out),
        .cmd_oe          (tx_cmd_oe),
        .cmd_done        (cmd_done),
        .cmd_sent        (cmd_sent)
    );

    sd_resp_rx i_resp_rx (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_sent        (cmd_sent),
        .cmd_oe          (cmd_oe),
        .cmd_resp_type   (cmd_resp_type),
        .cmd_in          (cmd_in),
        .resp_data       (resp_data),
        .resp_done       (resp_done),
        .resp_crc_err    (resp_crc_err)
    );

    // ======================================================================
    // Pin muxing
    // ======================================================================

    // Init sequence owns CMD and DAT while it holds them low
    assign cmd_oe  = drive_lines || tx_cmd_oe;
    assign cmd_out = drive_lines ? 1'b0 : tx_cmd_out;
    assign dat_oe  = drive_lines;

endmodule

`default_nettype wire

// ==== verification/sd_controller_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_controller_asserts (
    input wire clk_fast,
    input wire init_resetPulse,
    input wire cmd_trigger,
    input wire init_done,
    input wire drive_lines,
    input wire tx_cmd_oe,
    input wire cmd_done,
    input wire resp_done
);

    // Number of assertion failures so far
    int error_count = 0;

    // Init sequence and command tx never own CMD at the same time
    single_cmd_driver: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        !(drive_lines && tx_cmd_oe))
    else begin
        error_count++;
        $error("CMD driven by the init sequence and the command tx together");
    end

    // Commands are issued only after the card is initialized
    cmd_after_init: assert property (@(posedge clk_fast) disable iff (init_resetPulse)
        $changed(cmd_trigger) |-> init_done)
    else begin
        error_count++;
        $error("cmd_trigger toggled while init_done was low");
    end

    no_done_after_reset: assert property (@(posedge clk_fast)
        $fell(init_resetPulse) |=> ($stable(cmd_done) && $stable(resp_done)))
    else begin
        error_count++;
        $error("Done toggle in the first cycle after reset");
    end

endmodule

bind sd_controller sd_controller_asserts i_sd_controller_asserts (
    .clk_fast        (clk_fast),
    .init_resetPulse (init_resetPulse),
    .cmd_trigger     (cmd_trigger),
    .init_done       (init_done),
    .drive_lines     (drive_lines),
    .tx_cmd_oe       (tx_cmd_oe),
    .cmd_done        (cmd_done),
    .resp_done       (resp_done)
);

`default_nettype wire

// ==== verification/sd_controller_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_controller_tb;
    import sd_pkg::*;

    localparam int CLK_FREQ_HZ    = 1_000_000;
    localparam int INIT_FINISH_US = 10;

    // At 1 MHz one microsecond is one clk_fast cycle
    localparam int PULSE_CYCLES  = 15;
    localparam int HOLD_CYCLES   = 5;
    localparam int FINISH_CYCLES = 10;

    localparam int NUM_TESTS       = 5;
    localparam int MAX_DELAY       = 8 + 7;
    localparam int QUIET_CYCLES    = 100;
    localparam int INIT_TIME       = 4 + PULSE_CYCLES + HOLD_CYCLES + FINISH_CYCLES + 20;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (48 + 48 + MAX_DELAY + 20) + INIT_TIME
                                     + QUIET_CYCLES;

    typedef struct {
        string         name;
        sd_frame_t     cmd;
        sd_resp_type_e resp_type;
        logic [37:0]   resp_body;
        logic          bad_crc;
        logic          bad_end;
        int            delay;
    } test_t;

    logic          clk_fast;
    logic          init_resetPulse;
    logic          init_trigger;
    logic          cmd_trigger;
    sd_frame_t     cmd_data;
    sd_resp_type_e cmd_resp_type;
    logic          cmd_in;
    logic          sd_clk_en;
    logic          cmd_out;
    logic          cmd_oe;
    logic          dat_oe;
    logic          init_done;
    logic          cmd_done;
    logic          resp_done;
    sd_frame_t     resp_data;
    logic          resp_crc_err;

    test_t         tests [NUM_TESTS];
    logic [31:0]   lfsr_state;

    sd_controller #(
        .CLK_FREQ_HZ    (CLK_FREQ_HZ),
        .INIT_FINISH_US (INIT_FINISH_US)
    ) i_sd_controller (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .init_trigger    (init_trigger),
        .cmd_trigger     (cmd_trigger),
        .cmd_data        (cmd_data),
        .cmd_resp_type   (cmd_resp_type),
        .cmd_in          (cmd_in),
        .sd_clk_en       (sd_clk_en),
        .cmd_out         (cmd_out),
        .cmd_oe          (cmd_oe),
        .dat_oe          (dat_oe),
        .init_done       (init_done),
        .cmd_done        (cmd_done),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err)
    );

    initial begin
        clk_fast = 1'b0;
        forever begin
            #2 clk_fast = ~clk_fast;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_fast);
        fail_now("Watchdog expired before all tests finished");
    end

    // Protocol checker failures end the run right away
    always @(negedge clk_fast) begin
        if (i_sd_controller.i_sd_controller_asserts.error_count != 0) begin
            fail_now("A protocol assertion failed");
        end
    end

    // ======================================================================
    // Reference models
    // ======================================================================

    // Serial CRC7 over x^7 + x^3 + 1 taking the MSB first
    function automatic sd_crc7_t crc7_of(input logic [39:0] bits);
        sd_crc7_t r;
        logic     fb;
        int       i;
        r = '0;
        for (i = 39; i >= 0; i--) begin
            fb = bits[i] ^ r[6];
            r  = {r[5:0], 1'b0};
            if (fb) begin
                r = r ^ 7'h09;
            end
        end
        return r;
    endfunction

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic int random_bits(input int n);
        int value;
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // ======================================================================
    // Checks
    // ======================================================================

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_frame(input string name, input sd_frame_t expected,
                               input sd_frame_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_now($sformatf("Mismatch in %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            fail_now($sformatf("Mismatch in %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_init_sequence();
        int wait_cycles;
        int pulse_cycles;
        int hold_cycles;
        int finish_cycles;
        wait_cycles   = 0;
        pulse_cycles  = 0;
        hold_cycles   = 0;
        finish_cycles = 0;
        @(posedge clk_fast);
        init_trigger <= ~init_trigger;
        @(negedge clk_fast);
        while (sd_clk_en !== 1'b1) begin
            wait_cycles++;
            if (wait_cycles > 4) begin
                fail_now("sd_clk_en did not rise after the init trigger");
            end
            @(negedge clk_fast);
        end
        while (sd_clk_en === 1'b1) begin
            pulse_cycles++;
            check_bit("init pulse cmd_oe", 1'b1, cmd_oe);
            check_bit("init pulse dat_oe", 1'b1, dat_oe);
            check_bit("init pulse cmd_out", 1'b0, cmd_out);
            @(negedge clk_fast);
        end
        check_count("init pulse length", PULSE_CYCLES, pulse_cycles);
        while (dat_oe === 1'b1) begin
            hold_cycles++;
            check_bit("init hold cmd_oe", 1'b1, cmd_oe);
            check_bit("init hold cmd_out", 1'b0, cmd_out);
            @(negedge clk_fast);
        end
        check_count("init hold length", HOLD_CYCLES, hold_cycles);
        while (init_done !== 1'b1) begin
            finish_cycles++;
            check_bit("init release cmd_oe", 1'b0, cmd_oe);
            check_bit("init release sd_clk_en", 1'b0, sd_clk_en);
            @(negedge clk_fast);
        end
        check_count("init finish length", FINISH_CYCLES, finish_cycles);
        check_bit("init ready sd_clk_en", 1'b1, sd_clk_en);
    endtask

    // Starts and ends on a falling edge
    task automatic run_test(input test_t t);
        sd_frame_t sent;
        sd_frame_t expected;
        sd_frame_t reply;
        logic      last_done;
        logic      old_resp;
        int        oe_cycles;
        int        toggles;
        int        wait_cycles;
        int        delay;
        int        i;
        expected    = {t.cmd[47:8], crc7_of(t.cmd[47:8]), t.cmd[0]};
        sent        = '0;
        oe_cycles   = 0;
        toggles     = 0;
        wait_cycles = 0;
        last_done   = cmd_done;
        old_resp    = resp_done;
        @(posedge clk_fast);
        cmd_data      <= t.cmd;
        cmd_resp_type <= t.resp_type;
        cmd_trigger   <= ~cmd_trigger;
        @(negedge clk_fast);
        while (cmd_oe !== 1'b1) begin
            wait_cycles++;
            if (wait_cycles > 10) begin
                fail_now({t.name, ": cmd_oe did not rise after the command trigger"});
            end
            @(negedge clk_fast);
        end
        check_count({t.name, " cmd start latency"}, 2, wait_cycles);
        while (cmd_oe === 1'b1) begin
            sent = {sent[46:0], cmd_out};
            oe_cycles++;
            if (cmd_done !== last_done) begin
                toggles++;
                last_done = cmd_done;
            end
            @(negedge clk_fast);
        end
        if (cmd_done !== last_done) begin
            toggles++;
        end
        check_count({t.name, " cmd_oe cycles"}, SD_FRAME_BITS, oe_cycles);
        check_frame({t.name, " cmd frame"}, expected, sent);
        check_count({t.name, " cmd_done toggles"}, 1, toggles);

        if (t.resp_type == RESP_48) begin
            reply      = {2'b00, t.resp_body, 7'h00, 1'b1};
            reply[7:1] = crc7_of(reply[47:8]);
            if (t.bad_crc) begin
                reply[3] = ~reply[3];
            end
            if (t.bad_end) begin
                reply[0] = 1'b0;
            end
            delay = t.delay + random_bits(3);
            // Card stays off CMD until the turnaround is over
            repeat (SD_TURNAROUND_CYCLES + delay) @(posedge clk_fast);
            for (i = SD_FRAME_BITS - 1; i >= 0; i--) begin
                cmd_in <= reply[i];
                @(posedge clk_fast);
            end
            cmd_in <= 1'b1;
            wait_cycles = 0;
            @(negedge clk_fast);
            while (resp_done === old_resp) begin
                wait_cycles++;
                if (wait_cycles > 8) begin
                    fail_now({t.name, ": resp_done did not toggle after the reply"});
                end
                @(negedge clk_fast);
            end
            // Toggle lands 48 cycles after the start bit is sampled
            check_count({t.name, " resp latency"}, 1, wait_cycles);
            check_frame({t.name, " resp_data"}, reply, resp_data);
            check_bit({t.name, " resp_crc_err"}, t.bad_crc || t.bad_end, resp_crc_err);
            repeat (2) @(negedge clk_fast);
            check_bit({t.name, " resp_done held"}, ~old_resp, resp_done);
        end else begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk_fast);
                check_bit({t.name, " resp_done quiet"}, old_resp, resp_done);
            end
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        int n;
        lfsr_state      = 32'hed33_f600;
        init_resetPulse = 1'b1;
        init_trigger    = 1'b0;
        cmd_trigger     = 1'b0;
        cmd_data        = '0;
        cmd_resp_type   = RESP_NONE;
        cmd_in          = 1'b1;

        // name, command, response type, reply index and argument, bad CRC, bad end, delay
        tests[0] = '{"cmd0_go_idle", 48'h40_0000_0000_01, RESP_NONE,
                     38'h0, 1'b0, 1'b0, 0};
        tests[1] = '{"cmd8_if_cond", 48'h48_0000_01AA_01, RESP_48,
                     {6'd8, 32'h0000_01AA}, 1'b0, 1'b0, 0};
        tests[2] = '{"cmd55_app_cmd", 48'h77_0000_0000_01, RESP_48,
                     {6'd55, 32'h0000_0120}, 1'b0, 1'b0, 5};
        tests[3] = '{"cmd13_bad_crc", 48'h4D_1234_0000_01, RESP_48,
                     {6'd13, 32'h0000_0900}, 1'b1, 1'b0, 2};
        tests[4] = '{"cmd16_bad_end", 48'h50_0000_0200_01, RESP_48,
                     {6'd16, 32'h0000_0900}, 1'b0, 1'b1, 8};

        // CMD0 has the well known frame 40 00 00 00 00 95
        check_frame("crc7 reference", 48'h40_0000_0000_95,
                    {40'h40_0000_0000, crc7_of(40'h40_0000_0000), 1'b1});

        repeat (4) @(posedge clk_fast);
        init_resetPulse <= 1'b0;
        @(negedge clk_fast);
        check_bit("reset sd_clk_en", 1'b0, sd_clk_en);
        check_bit("reset cmd_oe", 1'b0, cmd_oe);
        check_bit("reset dat_oe", 1'b0, dat_oe);
        check_bit("reset init_done", 1'b0, init_done);
        check_bit("reset cmd_out", 1'b1, cmd_out);
        check_bit("reset cmd_done", 1'b0, cmd_done);
        check_bit("reset resp_done", 1'b0, resp_done);
        check_bit("reset resp_crc_err", 1'b0, resp_crc_err);
        check_frame("reset resp_data", '0, resp_data);

        check_init_sequence();
        for (n = 0; n < NUM_TESTS; n++) begin
            run_test(tests[n]);
        end

        if (i_sd_controller.i_sd_controller_asserts.error_count != 0) begin
            fail_now("Protocol assertions failed during the run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/sd_pkg.sv
rtl/sd_crc7.sv
rtl/sd_cmd_tx.sv
rtl/sd_resp_rx.sv
rtl/sd_init_seq.sv
rtl/sd_controller.sv
verification/sd_controller_asserts.sv
verification/sd_controller_tb.sv

// ==== Bender.yml ====
package:
  name: sd_controller

sources:
  - files:
      - rtl/sd_pkg.sv
      - rtl/sd_crc7.sv
      - rtl/sd_cmd_tx.sv
      - rtl/sd_resp_rx.sv
      - rtl/sd_init_seq.sv
      - rtl/sd_controller.sv
  - target: test
    files:
      - verification/sd_controller_asserts.sv
      - verification/sd_controller_tb.sv
